/* hw/soc_consts.svh */
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Bus widths
`define SOC_XLEN        32
`define SOC_STRB_W      4

// Memory map
`define SOC_SRAM_BASE   32'h8000_0000
`define SOC_SRAM_WORDS  1024            // 4 KiB of SRAM

// Console transmit register
`define SOC_UART_ADDR   32'ha000_03f8

// Low word of mtime, high word sits at +4
`define SOC_MTIME_ADDR  32'ha000_0048

`endif

/* hw/soc_pkg.sv */
`include "soc_consts.svh"

package soc_pkg;

    typedef logic [`SOC_XLEN-1:0]   word_t;
    typedef logic [`SOC_STRB_W-1:0] strb_t;

    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_op_e;

    // AXI style response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11
    } bus_resp_e;

    typedef enum logic [1:0] {
        DEV_SRAM,
        DEV_UART,
        DEV_CLINT,
        DEV_NONE
    } dev_sel_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ISSUE,
        ARB_WAIT,
        ARB_RESP
    } arb_state_e;

endpackage

/* hw/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_req_valid,
    output logic               fetch_req_ready,
    input  soc_pkg::word_t     fetch_addr,
    output logic               fetch_rsp_valid,
    input  logic               fetch_rsp_ready,
    output soc_pkg::word_t     fetch_rdata,
    output soc_pkg::bus_resp_e fetch_resp,
    input  logic               lsu_req_valid,
    output logic               lsu_req_ready,
    input  soc_pkg::bus_op_e   lsu_op,
    input  soc_pkg::word_t     lsu_addr,
    input  soc_pkg::word_t     lsu_wdata,
    input  soc_pkg::strb_t     lsu_wstrb,
    output logic               lsu_rsp_valid,
    input  logic               lsu_rsp_ready,
    output soc_pkg::word_t     lsu_rdata,
    output soc_pkg::bus_resp_e lsu_resp,
    output logic               bus_valid,
    output soc_pkg::bus_op_e   bus_op,
    output soc_pkg::word_t     bus_addr,
    output soc_pkg::word_t     bus_wdata,
    output soc_pkg::strb_t     bus_wstrb,
    input  logic               bus_rsp_valid,
    input  soc_pkg::word_t     bus_rdata,
    input  soc_pkg::bus_resp_e bus_resp
);

    soc_pkg::arb_state_e state;
    logic                lsu_owner;     // Set while the load/store port owns the bus
    logic                lsu_grant;
    logic                fetch_grant;
    logic                rsp_done;
    soc_pkg::word_t      rsp_rdata;
    soc_pkg::bus_resp_e  rsp_resp;

    // Load/store wins a tie
    assign lsu_grant   = (state == soc_pkg::ARB_IDLE) && lsu_req_valid;
    assign fetch_grant = (state == soc_pkg::ARB_IDLE) && fetch_req_valid && !lsu_req_valid;

    assign lsu_req_ready   = lsu_grant;
    assign fetch_req_ready = fetch_grant;

    assign rsp_done = lsu_owner ? lsu_rsp_ready : fetch_rsp_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= soc_pkg::ARB_IDLE;
            lsu_owner <= 1'b0;
        end else begin
            case (state)
                soc_pkg::ARB_IDLE: begin
                    if (lsu_grant || fetch_grant) begin
                        state     <= soc_pkg::ARB_ISSUE;
                        lsu_owner <= lsu_grant;
                    end
                end
                soc_pkg::ARB_ISSUE: state <= soc_pkg::ARB_WAIT;
                soc_pkg::ARB_WAIT: begin
                    if (bus_rsp_valid) state <= soc_pkg::ARB_RESP;
                end
                soc_pkg::ARB_RESP: begin
                    if (rsp_done) state <= soc_pkg::ARB_IDLE;
                end
                default: state <= soc_pkg::ARB_IDLE;
            endcase
        end
    end

    // Request and response holding registers
    always_ff @(posedge clk) begin
        if (lsu_grant) begin
            bus_op    <= lsu_op;
            bus_addr  <= lsu_addr;
            bus_wdata <= lsu_wdata;
            bus_wstrb <= lsu_wstrb;
        end else if (fetch_grant) begin
            bus_op    <= soc_pkg::BUS_READ;   // Fetch is always a word read
            bus_addr  <= fetch_addr;
            bus_wdata <= '0;
            bus_wstrb <= '0;
        end
        if (state == soc_pkg::ARB_WAIT && bus_rsp_valid) begin
            rsp_rdata <= bus_rdata;
            rsp_resp  <= bus_resp;
        end
    end

    assign bus_valid = (state == soc_pkg::ARB_ISSUE);

    assign lsu_rsp_valid   = (state == soc_pkg::ARB_RESP) && lsu_owner;
    assign fetch_rsp_valid = (state == soc_pkg::ARB_RESP) && !lsu_owner;
    assign lsu_rdata       = rsp_rdata;
    assign lsu_resp        = rsp_resp;
    assign fetch_rdata     = rsp_rdata;
    assign fetch_resp      = rsp_resp;

endmodule

/* hw/device_decoder.sv */
`timescale 1ns/1ps
`include "soc_consts.svh"

module device_decoder (
    input  logic               clk,
    input  logic               rst,
    input  logic               bus_valid,
    input  soc_pkg::word_t     bus_addr,
    output logic               sram_valid,
    output logic               uart_valid,
    output logic               clint_valid,
    input  logic               sram_rsp_valid,
    input  soc_pkg::word_t     sram_rdata,
    input  logic               uart_rsp_valid,
    input  soc_pkg::word_t     uart_rdata,
    input  logic               clint_rsp_valid,
    input  soc_pkg::word_t     clint_rdata,
    output logic               bus_rsp_valid,
    output soc_pkg::word_t     bus_rdata,
    output soc_pkg::bus_resp_e bus_resp
);

    localparam soc_pkg::word_t sram_base  = `SOC_SRAM_BASE;
    localparam soc_pkg::word_t sram_span  = `SOC_SRAM_WORDS * 4;
    localparam soc_pkg::word_t uart_addr  = `SOC_UART_ADDR;
    localparam soc_pkg::word_t mtime_addr = `SOC_MTIME_ADDR;

    soc_pkg::dev_sel_e sel;
    logic              dec_err_valid;   // Unmapped access answered here
    logic              rsp_any;
    soc_pkg::word_t    rsp_data;

    always_comb begin
        if (bus_addr - sram_base < sram_span)
            sel = soc_pkg::DEV_SRAM;
        else if (bus_addr[31:2] == uart_addr[31:2])
            sel = soc_pkg::DEV_UART;
        else if (bus_addr[31:3] == mtime_addr[31:3])   // Both mtime words
            sel = soc_pkg::DEV_CLINT;
        else
            sel = soc_pkg::DEV_NONE;
    end

    assign sram_valid  = bus_valid && (sel == soc_pkg::DEV_SRAM);
    assign uart_valid  = bus_valid && (sel == soc_pkg::DEV_UART);
    assign clint_valid = bus_valid && (sel == soc_pkg::DEV_CLINT);

    assign rsp_any  = sram_rsp_valid || uart_rsp_valid || clint_rsp_valid || dec_err_valid;
    assign rsp_data = sram_rsp_valid  ? sram_rdata  :
                      uart_rsp_valid  ? uart_rdata  :
                      clint_rsp_valid ? clint_rdata : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_err_valid <= 1'b0;
            bus_rsp_valid <= 1'b0;
        end else begin
            dec_err_valid <= bus_valid && (sel == soc_pkg::DEV_NONE);
            bus_rsp_valid <= rsp_any;
        end
    end

    // Registered return path
    always_ff @(posedge clk) begin
        bus_rdata <= rsp_data;
        if (dec_err_valid)
            bus_resp <= soc_pkg::RESP_DECERR;
        else
            bus_resp <= soc_pkg::RESP_OKAY;
    end

endmodule

/* hw/sram_device.sv */
`timescale 1ns/1ps
`include "soc_consts.svh"

module sram_device #(
    parameter int WORDS = `SOC_SRAM_WORDS
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             sram_valid,
    input  soc_pkg::bus_op_e bus_op,
    input  soc_pkg::word_t   bus_addr,
    input  soc_pkg::word_t   bus_wdata,
    input  soc_pkg::strb_t   bus_wstrb,
    output logic             sram_rsp_valid,
    output soc_pkg::word_t   sram_rdata
);

    localparam int idx_w = $clog2(WORDS);

    soc_pkg::word_t   mem [WORDS];
    logic [idx_w-1:0] idx;

    assign idx = bus_addr[idx_w+1:2];   // Word address

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            sram_rsp_valid <= 1'b0;
        else
            sram_rsp_valid <= sram_valid;
    end

    // Old word comes back on writes too
    always_ff @(posedge clk) begin
        if (sram_valid) begin
            sram_rdata <= mem[idx];
            if (bus_op == soc_pkg::BUS_WRITE) begin
                for (int b = 0; b < `SOC_STRB_W; b++) begin
                    if (bus_wstrb[b])
                        mem[idx][8*b +: 8] <= bus_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* hw/uart_device.sv */
`timescale 1ns/1ps

module uart_device (
    input  logic             clk,
    input  logic             rst,
    input  logic             uart_valid,
    input  soc_pkg::bus_op_e bus_op,
    input  soc_pkg::word_t   bus_wdata,
    output logic             uart_rsp_valid,
    output soc_pkg::word_t   uart_rdata,
    output logic             uart_tx_valid,
    input  logic             uart_tx_ready,
    output logic [7:0]       uart_tx_data
);

    logic wr_req;
    logic rd_req;

    assign wr_req = uart_valid && (bus_op == soc_pkg::BUS_WRITE);
    assign rd_req = uart_valid && (bus_op == soc_pkg::BUS_READ);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            uart_tx_valid  <= 1'b0;
            uart_rsp_valid <= 1'b0;
        end else begin
            uart_rsp_valid <= rd_req;   // Reads answer right away
            if (wr_req) begin
                uart_tx_valid <= 1'b1;
            end else if (uart_tx_valid && uart_tx_ready) begin
                uart_tx_valid  <= 1'b0;
                uart_rsp_valid <= 1'b1; // Ack once the char is taken
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_req)
            uart_tx_data <= bus_wdata[7:0];
    end

    // Transmit-only register, nothing to read back
    assign uart_rdata = '0;

endmodule

/* hw/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer (
    input  logic             clk,
    input  logic             rst,
    input  logic             clint_valid,
    input  soc_pkg::bus_op_e bus_op,
    input  soc_pkg::word_t   bus_addr,
    output logic             clint_rsp_valid,
    output soc_pkg::word_t   clint_rdata
);

    logic [63:0] mtime;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtime           <= '0;
            clint_rsp_valid <= 1'b0;
        end else begin
            mtime           <= mtime + 64'd1;
            clint_rsp_valid <= clint_valid;
        end
    end

    // Writes get an ack and zero data
    always_ff @(posedge clk) begin
        if (clint_valid) begin
            if (bus_op == soc_pkg::BUS_WRITE)
                clint_rdata <= '0;
            else if (bus_addr[2])
                clint_rdata <= mtime[63:32];
            else
                clint_rdata <= mtime[31:0];
        end
    end

endmodule

/* hw/soc_top.sv */
`timescale 1ns/1ps

module soc_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_req_valid,
    output logic               fetch_req_ready,
    input  soc_pkg::word_t     fetch_addr,
    output logic               fetch_rsp_valid,
    input  logic               fetch_rsp_ready,
    output soc_pkg::word_t     fetch_rdata,
    output soc_pkg::bus_resp_e fetch_resp,
    input  logic               lsu_req_valid,
    output logic               lsu_req_ready,
    input  soc_pkg::bus_op_e   lsu_op,
    input  soc_pkg::word_t     lsu_addr,
    input  soc_pkg::word_t     lsu_wdata,
    input  soc_pkg::strb_t     lsu_wstrb,
    output logic               lsu_rsp_valid,
    input  logic               lsu_rsp_ready,
    output soc_pkg::word_t     lsu_rdata,
    output soc_pkg::bus_resp_e lsu_resp,
    output logic               uart_tx_valid,
    input  logic               uart_tx_ready,
    output logic [7:0]         uart_tx_data
);

    // Shared bus from the arbiter
    logic               bus_valid;
    soc_pkg::bus_op_e   bus_op;
    soc_pkg::word_t     bus_addr;
    soc_pkg::word_t     bus_wdata;
    soc_pkg::strb_t     bus_wstrb;
    logic               bus_rsp_valid;
    soc_pkg::word_t     bus_rdata;
    soc_pkg::bus_resp_e bus_resp;

    logic               sram_valid;
    logic               sram_rsp_valid;
    soc_pkg::word_t     sram_rdata;
    logic               uart_valid;
    logic               uart_rsp_valid;
    soc_pkg::word_t     uart_rdata;
    logic               clint_valid;
    logic               clint_rsp_valid;
    soc_pkg::word_t     clint_rdata;

    bus_arbiter u_arbiter (
        .clk             (clk),
        .rst             (rst),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req_ready (fetch_req_ready),
        .fetch_addr      (fetch_addr),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp_ready (fetch_rsp_ready),
        .fetch_rdata     (fetch_rdata),
        .fetch_resp      (fetch_resp),
        .lsu_req_valid   (lsu_req_valid),
        .lsu_req_ready   (lsu_req_ready),
        .lsu_op          (lsu_op),
        .lsu_addr        (lsu_addr),
        .lsu_wdata       (lsu_wdata),
        .lsu_wstrb       (lsu_wstrb),
        .lsu_rsp_valid   (lsu_rsp_valid),
        .lsu_rsp_ready   (lsu_rsp_ready),
        .lsu_rdata       (lsu_rdata),
        .lsu_resp        (lsu_resp),
        .bus_valid       (bus_valid),
        .bus_op          (bus_op),
        .bus_addr        (bus_addr),
        .bus_wdata       (bus_wdata),
        .bus_wstrb       (bus_wstrb),
        .bus_rsp_valid   (bus_rsp_valid),
        .bus_rdata       (bus_rdata),
        .bus_resp        (bus_resp)
    );

    device_decoder u_decoder (
        .clk             (clk),
        .rst             (rst),
        .bus_valid       (bus_valid),
        .bus_addr        (bus_addr),
        .sram_valid      (sram_valid),
        .uart_valid      (uart_valid),
        .clint_valid     (clint_valid),
        .sram_rsp_valid  (sram_rsp_valid),
        .sram_rdata      (sram_rdata),
        .uart_rsp_valid  (uart_rsp_valid),
        .uart_rdata      (uart_rdata),
        .clint_rsp_valid (clint_rsp_valid),
        .clint_rdata     (clint_rdata),
        .bus_rsp_valid   (bus_rsp_valid),
        .bus_rdata       (bus_rdata),
        .bus_resp        (bus_resp)
    );

    sram_device u_sram (
        .clk            (clk),
        .rst            (rst),
        .sram_valid     (sram_valid),
        .bus_op         (bus_op),
        .bus_addr       (bus_addr),
        .bus_wdata      (bus_wdata),
        .bus_wstrb      (bus_wstrb),
        .sram_rsp_valid (sram_rsp_valid),
        .sram_rdata     (sram_rdata)
    );

    uart_device u_uart (
        .clk            (clk),
        .rst            (rst),
        .uart_valid     (uart_valid),
        .bus_op         (bus_op),
        .bus_wdata      (bus_wdata),
        .uart_rsp_valid (uart_rsp_valid),
        .uart_rdata     (uart_rdata),
        .uart_tx_valid  (uart_tx_valid),
        .uart_tx_ready  (uart_tx_ready),
        .uart_tx_data   (uart_tx_data)
    );

    clint_timer u_clint (
        .clk             (clk),
        .rst             (rst),
        .clint_valid     (clint_valid),
        .bus_op          (bus_op),
        .bus_addr        (bus_addr),
        .clint_rsp_valid (clint_rsp_valid),
        .clint_rdata     (clint_rdata)
    );

endmodule

/* tb/soc_tb.sv */
`timescale 1ns/1ps
`include "soc_consts.svh"

module soc_tb;

    localparam int timeout_cycles = 200;

    logic               clk = 1'b0;
    logic               rst;
    logic               fetch_req_valid;
    logic               fetch_req_ready;
    soc_pkg::word_t     fetch_addr;
    logic               fetch_rsp_valid;
    logic               fetch_rsp_ready;
    soc_pkg::word_t     fetch_rdata;
    soc_pkg::bus_resp_e fetch_resp;
    logic               lsu_req_valid;
    logic               lsu_req_ready;
    soc_pkg::bus_op_e   lsu_op;
    soc_pkg::word_t     lsu_addr;
    soc_pkg::word_t     lsu_wdata;
    soc_pkg::strb_t     lsu_wstrb;
    logic               lsu_rsp_valid;
    logic               lsu_rsp_ready;
    soc_pkg::word_t     lsu_rdata;
    soc_pkg::bus_resp_e lsu_resp;
    logic               uart_tx_valid;
    logic               uart_tx_ready;
    logic [7:0]         uart_tx_data;

    soc_pkg::word_t     shadow [`SOC_SRAM_WORDS];  // Reference SRAM image
    logic               held_valid = 1'b0;
    soc_pkg::word_t     held_data;
    soc_pkg::bus_resp_e held_resp;

    soc_top u_dut (.*);

    always #4 clk = ~clk;

    task automatic fail_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        $display("** Error at %0d ns: %s", $time, msg);
        fail_run();
    endtask

    task automatic timeout_fail(input string what);
        $display("Gave up after %0d cycles waiting for %s", timeout_cycles, what);
        fail_run();
    endtask

    task automatic check_word(input soc_pkg::word_t got, input soc_pkg::word_t exp,
                              input string what);
        if (got !== exp)
            value_error($sformatf("%s is 0x%08h, expected 0x%08h", what, got, exp));
    endtask

    task automatic check_resp(input soc_pkg::bus_resp_e got, input soc_pkg::bus_resp_e exp,
                              input string what);
        if (got !== exp)
            value_error($sformatf("%s response is %s, expected %s", what, got.name(), exp.name()));
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp)
            value_error($sformatf("%s is 0x%02h, expected 0x%02h", what, got, exp));
    endtask

    function automatic logic in_sram(input soc_pkg::word_t addr);
        return addr >= `SOC_SRAM_BASE && addr < `SOC_SRAM_BASE + 4 * `SOC_SRAM_WORDS;
    endfunction

    function automatic soc_pkg::word_t sram_addr(input int idx);
        return `SOC_SRAM_BASE + 4 * idx;
    endfunction

    function automatic soc_pkg::bus_resp_e expect_resp(input soc_pkg::word_t addr);
        if (in_sram(addr) || addr == `SOC_UART_ADDR || addr == `SOC_MTIME_ADDR
                || addr == (`SOC_MTIME_ADDR + 4))
            return soc_pkg::RESP_OKAY;
        return soc_pkg::RESP_DECERR;
    endfunction

    function automatic soc_pkg::word_t expect_rdata(input soc_pkg::word_t addr);
        if (in_sram(addr))
            return shadow[(addr - `SOC_SRAM_BASE) >> 2];
        return '0;   // Unmapped reads come back as zero
    endfunction

    // Merges strobed bytes into the shadow image, returns the word before the write
    function automatic soc_pkg::word_t model_write(input soc_pkg::word_t addr,
                                                   input soc_pkg::word_t wdata,
                                                   input soc_pkg::strb_t strb);
        soc_pkg::word_t old;
        int             idx;
        if (!in_sram(addr))
            return '0;
        idx = (addr - `SOC_SRAM_BASE) >> 2;
        old = shadow[idx];
        for (int b = 0; b < `SOC_STRB_W; b++) begin
            if (strb[b])
                shadow[idx][8*b +: 8] = wdata[8*b +: 8];
        end
        return old;
    endfunction

    task automatic drive_lsu(input soc_pkg::bus_op_e op, input soc_pkg::word_t addr,
                             input soc_pkg::word_t wdata, input soc_pkg::strb_t strb);
        lsu_req_valid <= 1'b1;
        lsu_op        <= op;
        lsu_addr      <= addr;
        lsu_wdata     <= wdata;
        lsu_wstrb     <= strb;
    endtask

    task automatic drive_fetch(input soc_pkg::word_t addr);
        fetch_req_valid <= 1'b1;
        fetch_addr      <= addr;
    endtask

    task automatic wait_lsu_grant();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > timeout_cycles) timeout_fail("lsu_req_ready");
        end while (!lsu_req_ready);
        @(posedge clk);   // Handshake edge
        lsu_req_valid <= 1'b0;
    endtask

    task automatic wait_fetch_grant();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > timeout_cycles) timeout_fail("fetch_req_ready");
        end while (!fetch_req_ready);
        @(posedge clk);
        fetch_req_valid <= 1'b0;
    endtask

    task automatic take_lsu_rsp(input int stall, output soc_pkg::word_t data,
                                output soc_pkg::bus_resp_e resp);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > timeout_cycles) timeout_fail("lsu_rsp_valid");
        end while (!lsu_rsp_valid);
        data = lsu_rdata;
        resp = lsu_resp;
        repeat (stall) @(negedge clk);   // Stability is checked by the monitor
        @(posedge clk);
        lsu_rsp_ready <= 1'b1;
        @(posedge clk);
        lsu_rsp_ready <= 1'b0;
    endtask

    task automatic take_fetch_rsp(output soc_pkg::word_t data, output soc_pkg::bus_resp_e resp);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > timeout_cycles) timeout_fail("fetch_rsp_valid");
        end while (!fetch_rsp_valid);
        data = fetch_rdata;
        resp = fetch_resp;
        @(posedge clk);
        fetch_rsp_ready <= 1'b1;
        @(posedge clk);
        fetch_rsp_ready <= 1'b0;
    endtask

    task automatic wait_uart_char();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > timeout_cycles) timeout_fail("uart_tx_valid");
        end while (!uart_tx_valid);
    endtask

    task automatic lsu_access(input soc_pkg::bus_op_e op, input soc_pkg::word_t addr,
                              input soc_pkg::word_t wdata, input soc_pkg::strb_t strb,
                              output soc_pkg::word_t data, output soc_pkg::bus_resp_e resp);
        @(posedge clk);
        drive_lsu(op, addr, wdata, strb);
        wait_lsu_grant();
        take_lsu_rsp($urandom % 5, data, resp);
    endtask

    task automatic fetch_read(input soc_pkg::word_t addr, output soc_pkg::word_t data,
                              output soc_pkg::bus_resp_e resp);
        @(posedge clk);
        drive_fetch(addr);
        wait_fetch_grant();
        take_fetch_rsp(data, resp);
    endtask

    // A stalled lsu response must hold valid and payload
    always @(negedge clk) begin
        if (held_valid && !lsu_rsp_valid) begin
            $display("lsu_rsp_valid dropped before the response was taken");
            fail_run();
        end
        if (held_valid && lsu_rsp_valid) begin
            check_word(lsu_rdata, held_data, "stalled lsu data");
            check_resp(lsu_resp, held_resp, "stalled lsu");
        end
        held_valid = (lsu_rsp_valid === 1'b1) && !lsu_rsp_ready;
        held_data  = lsu_rdata;
        held_resp  = lsu_resp;
    end

    initial begin
        soc_pkg::word_t     addr;
        soc_pkg::word_t     wd;
        soc_pkg::word_t     old;
        soc_pkg::word_t     data;
        soc_pkg::word_t     t0;
        soc_pkg::word_t     t1;
        soc_pkg::bus_resp_e resp;
        soc_pkg::strb_t     strb;
        int                 idx [8];
        int                 stall;

        void'($urandom(32'hb67b_7de4));
        rst             = 1'b1;
        fetch_req_valid = 1'b0;
        fetch_addr      = '0;
        fetch_rsp_ready = 1'b0;
        lsu_req_valid   = 1'b0;
        lsu_op          = soc_pkg::BUS_READ;
        lsu_addr        = '0;
        lsu_wdata       = '0;
        lsu_wstrb       = '0;
        lsu_rsp_ready   = 1'b0;
        uart_tx_ready   = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Full words first so later partial writes merge into known data
        for (int i = 0; i < 8; i++) begin
            idx[i] = ($urandom % 128) * 8 + i;
            addr   = sram_addr(idx[i]);
            wd     = $urandom;
            old    = model_write(addr, wd, 4'hf);
            lsu_access(soc_pkg::BUS_WRITE, addr, wd, 4'hf, data, resp);
            check_resp(resp, expect_resp(addr), "sram full write");
        end
        for (int i = 0; i < 8; i++) begin
            addr = sram_addr(idx[i]);
            wd   = $urandom;
            strb = soc_pkg::strb_t'($urandom);
            old  = model_write(addr, wd, strb);
            lsu_access(soc_pkg::BUS_WRITE, addr, wd, strb, data, resp);
            check_word(data, old, "sram old word on write");
            check_resp(resp, expect_resp(addr), "sram strobed write");
        end
        for (int i = 0; i < 8; i++) begin
            addr = sram_addr(idx[i]);
            lsu_access(soc_pkg::BUS_READ, addr, '0, '0, data, resp);
            check_word(data, expect_rdata(addr), "sram lsu read");
            check_resp(resp, expect_resp(addr), "sram lsu read");
            fetch_read(addr, data, resp);
            check_word(data, expect_rdata(addr), "sram fetch read");
            check_resp(resp, expect_resp(addr), "sram fetch read");
        end

        // Both masters in the same cycle, lsu goes first
        @(posedge clk);
        drive_lsu(soc_pkg::BUS_READ, sram_addr(idx[0]), '0, '0);
        drive_fetch(sram_addr(idx[1]));
        wait_lsu_grant();
        take_lsu_rsp(2, data, resp);
        check_word(data, expect_rdata(sram_addr(idx[0])), "arbitrated lsu read");
        check_resp(resp, soc_pkg::RESP_OKAY, "arbitrated lsu read");
        wait_fetch_grant();
        take_fetch_rsp(data, resp);
        check_word(data, expect_rdata(sram_addr(idx[1])), "arbitrated fetch read");
        check_resp(resp, soc_pkg::RESP_OKAY, "arbitrated fetch read");

        for (int k = 0; k < 3; k++) begin
            wd = $urandom;
            @(posedge clk);
            drive_lsu(soc_pkg::BUS_WRITE, `SOC_UART_ADDR, wd, 4'h1);
            wait_lsu_grant();
            wait_uart_char();
            check_byte(uart_tx_data, wd[7:0], "uart character");
            stall = 1 + $urandom % 8;
            repeat (stall) begin
                @(negedge clk);
                if (lsu_rsp_valid || !uart_tx_valid) begin
                    $display("UART write finished while uart_tx_ready was held low");
                    fail_run();
                end
            end
            @(posedge clk);
            uart_tx_ready <= 1'b1;
            @(posedge clk);
            uart_tx_ready <= 1'b0;
            take_lsu_rsp(0, data, resp);
            check_resp(resp, expect_resp(`SOC_UART_ADDR), "uart write");
        end

        lsu_access(soc_pkg::BUS_READ, `SOC_MTIME_ADDR, '0, '0, t0, resp);
        check_resp(resp, expect_resp(`SOC_MTIME_ADDR), "mtime low read");
        lsu_access(soc_pkg::BUS_READ, `SOC_MTIME_ADDR, '0, '0, t1, resp);
        if (!(t1 > t0 && t1 - t0 >= 4))
            value_error($sformatf("mtime went from 0x%08h to 0x%08h", t0, t1));
        lsu_access(soc_pkg::BUS_READ, (`SOC_MTIME_ADDR + 4), '0, '0, data, resp);
        check_word(data, '0, "mtime high word");
        check_resp(resp, expect_resp(`SOC_MTIME_ADDR + 4), "mtime high read");

        addr = 32'h1000_0000;
        lsu_access(soc_pkg::BUS_READ, addr, '0, '0, data, resp);
        check_word(data, expect_rdata(addr), "unmapped read");
        check_resp(resp, expect_resp(addr), "unmapped read");
        addr = sram_addr(`SOC_SRAM_WORDS + idx[0]);   // Aliases idx[0] if decoded wrongly
        wd   = $urandom;
        old  = model_write(addr, wd, 4'hf);
        lsu_access(soc_pkg::BUS_WRITE, addr, wd, 4'hf, data, resp);
        check_word(data, expect_rdata(addr), "unmapped write");
        check_resp(resp, expect_resp(addr), "unmapped write");
        lsu_access(soc_pkg::BUS_READ, sram_addr(idx[0]), '0, '0, data, resp);
        check_word(data, expect_rdata(sram_addr(idx[0])), "sram after unmapped write");

        repeat (2) @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

/* compile.f */
+incdir+hw
hw/soc_pkg.sv
hw/bus_arbiter.sv
hw/device_decoder.sv
hw/sram_device.sv
hw/uart_device.sv
hw/clint_timer.sv
hw/soc_top.sv
tb/soc_tb.sv

/* Bender.yml */
package:
  name: soc_mem

export_include_dirs:
  - hw

sources:
  - hw/soc_pkg.sv
  - hw/bus_arbiter.sv
  - hw/device_decoder.sv
  - hw/sram_device.sv
  - hw/uart_device.sv
  - hw/clint_timer.sv
  - hw/soc_top.sv
  - target: test
    files:
      - tb/soc_tb.sv
